//--- icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch byte address
`define ICACHE_ADDR_W 32

// 16 byte lines
`define ICACHE_OFFSET_W 4

// 4 sets, direct mapped
`define ICACHE_INDEX_W 2

// also the refill burst length
`define ICACHE_WORDS 4

`endif

//--- icache_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_consts.svh"

module icache_ctrl (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ar_valid,
  input  logic [`ICACHE_ADDR_W-1:0] ar_addr,
  output logic                      ar_ready,
  output logic                      r_valid,
  output icache_pkg::word_t         r_data,
  input  logic                      r_ready,
  input  logic                      flush_req,
  output logic                      flush_ack,
  output logic [31:0]               hit_count,
  output logic [31:0]               miss_count,
  output icache_pkg::index_t        lookup_index,
  output icache_pkg::tag_t          lookup_tag,
  output logic                      fill,
  output logic                      invalidate,
  input  logic                      hit,
  output icache_pkg::index_t        rd_index,
  output icache_pkg::woff_t         rd_off,
  input  icache_pkg::word_t         rd_word,
  output logic                      start,
  output logic                      bypass,
  output logic [`ICACHE_ADDR_W-1:0] word_addr,
  input  logic                      done,
  input  icache_pkg::word_t         bypass_word
);

  typedef enum logic [2:0] {s_idle, s_lookup, s_refill, s_respond, s_flush} state_t;

  state_t                    state;
  logic                      acc_q;
  logic                      was_hit;
  logic [`ICACHE_ADDR_W-1:0] addr_q;
  logic                      cacheable;
  logic                      ar_hs;

  assign cacheable    = icache_pkg::is_cacheable(addr_q);
  assign ar_ready     = (state == s_idle) && !acc_q;
  assign ar_hs        = ar_valid && ar_ready;
  assign lookup_index = icache_pkg::addr_index(addr_q);
  assign lookup_tag   = icache_pkg::addr_tag(addr_q);
  assign rd_index     = lookup_index;
  assign rd_off       = icache_pkg::addr_woff(addr_q);
  assign word_addr    = addr_q;
  assign bypass       = !cacheable;
  assign start        = (state == s_lookup) && !(hit && cacheable);
  assign fill         = (state == s_refill) && done && cacheable;
  // fetch beats flush when both show up
  assign invalidate   = (state == s_idle) && !acc_q && !ar_valid && flush_req;
  assign r_valid      = (state == s_respond);
  assign r_data       = cacheable ? rd_word : bypass_word;
  assign flush_ack    = (state == s_flush);

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      addr_q <= ar_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= s_idle;
      acc_q      <= 1'b0;
      was_hit    <= 1'b0;
      hit_count  <= '0;
      miss_count <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (acc_q) begin
            acc_q <= 1'b0;
            state <= s_lookup;
          end else if (ar_hs) begin
            acc_q <= 1'b1; // address registered, tags next cycle
          end else if (invalidate) begin
            state <= s_flush;
          end
        end
        s_lookup: begin
          was_hit <= hit && cacheable;
          state   <= (hit && cacheable) ? s_respond : s_refill;
        end
        s_refill: if (done) state <= s_respond;
        s_respond: begin
          if (r_ready) begin
            state <= s_idle;
            if (cacheable && was_hit) hit_count <= hit_count + 1'b1;
            if (cacheable && !was_hit) miss_count <= miss_count + 1'b1;
          end
        end
        s_flush: if (!flush_req) state <= s_idle; // ack drops after req
        default: state <= s_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- icache_data_store.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_consts.svh"

module icache_data_store (
  input  logic               clk,
  input  logic               wr_en,
  input  icache_pkg::index_t wr_index,
  input  icache_pkg::woff_t  wr_off,
  input  icache_pkg::word_t  wr_word,
  input  icache_pkg::index_t rd_index,
  input  icache_pkg::woff_t  rd_off,
  output icache_pkg::word_t  rd_word
);

  localparam int SETS = 1 << `ICACHE_INDEX_W;

  icache_pkg::word_t lines [SETS][`ICACHE_WORDS];

  // one word per refill beat
  always_ff @(posedge clk) begin
    if (wr_en) begin
      lines[wr_index][wr_off] <= wr_word;
    end
  end

  assign rd_word = lines[rd_index][rd_off]; // async read

endmodule

`default_nettype wire

//--- icache_pkg.sv
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_W-`ICACHE_INDEX_W-`ICACHE_OFFSET_W-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_OFFSET_W-3:0] woff_t; // word within a line
  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t; // one memory data beat

  function automatic tag_t addr_tag(input logic [`ICACHE_ADDR_W-1:0] addr);
    return addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W+`ICACHE_INDEX_W];
  endfunction

  function automatic index_t addr_index(input logic [`ICACHE_ADDR_W-1:0] addr);
    return addr[`ICACHE_OFFSET_W+`ICACHE_INDEX_W-1:`ICACHE_OFFSET_W];
  endfunction

  function automatic woff_t addr_woff(input logic [`ICACHE_ADDR_W-1:0] addr);
    return addr[`ICACHE_OFFSET_W-1:2];
  endfunction

  // on-chip sram below 0x3000_0000 is left uncached
  function automatic logic is_cacheable(input logic [`ICACHE_ADDR_W-1:0] addr);
    return addr[`ICACHE_ADDR_W-1 -: 4] >= 4'h3;
  endfunction

endpackage

`default_nettype wire

//--- icache_refill.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_consts.svh"

module icache_refill (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      start,
  input  logic                      bypass,
  input  logic [`ICACHE_ADDR_W-1:0] word_addr,
  output logic                      done,
  output icache_pkg::word_t         bypass_word,
  output logic                      wr_en,
  output icache_pkg::index_t        wr_index,
  output icache_pkg::woff_t         wr_off,
  output icache_pkg::word_t         wr_word,
  output logic                      mem_ar_valid,
  output logic [`ICACHE_ADDR_W-1:0] mem_ar_addr,
  output logic [7:0]                mem_ar_len,
  input  logic                      mem_ar_ready,
  input  logic                      mem_r_valid,
  input  icache_pkg::beat_t         mem_r_data,
  input  logic                      mem_r_last,
  output logic                      mem_r_ready
);

  logic               byp_q;
  icache_pkg::index_t idx_q;
  icache_pkg::woff_t  off_q;
  icache_pkg::word_t  beat_word;
  logic               beat_hs;

  assign beat_hs = mem_r_valid && mem_r_ready;
  assign beat_word = off_q[0] ? mem_r_data[63:32] : mem_r_data[31:0]; // odd words up top

  assign wr_en    = beat_hs && !byp_q;
  assign wr_index = idx_q;
  assign wr_off   = off_q;
  assign wr_word  = beat_word;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      mem_ar_valid <= 1'b0;
      mem_r_ready  <= 1'b0;
      done         <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        mem_ar_valid <= 1'b1;
        mem_r_ready  <= 1'b1; // held for the whole burst
      end else if (mem_ar_valid && mem_ar_ready) begin
        mem_ar_valid <= 1'b0;
      end
      if (beat_hs && mem_r_last) begin
        mem_r_ready <= 1'b0;
        done        <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mem_ar_addr <= word_addr;
      mem_ar_len  <= bypass ? 8'd0 : 8'(`ICACHE_WORDS - 1);
      byp_q       <= bypass;
      idx_q       <= icache_pkg::addr_index(word_addr);
      off_q       <= icache_pkg::addr_woff(word_addr); // critical word first
    end else if (beat_hs) begin
      off_q <= off_q + 1'b1; // wraps inside the line
      if (byp_q) begin
        bypass_word <= beat_word;
      end
    end
  end

endmodule

`default_nettype wire

//--- icache_tag_store.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_consts.svh"

module icache_tag_store (
  input  logic               clk,
  input  logic               rstn,
  input  icache_pkg::index_t lookup_index,
  input  icache_pkg::tag_t   lookup_tag,
  input  logic               fill,
  input  logic               invalidate,
  output logic               hit
);

  localparam int SETS = 1 << `ICACHE_INDEX_W;

  logic [SETS-1:0] valid;
  icache_pkg::tag_t tags [SETS];

  assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid <= '0;
    end else if (invalidate) begin
      valid <= '0; // fence.i drops every line
    end else if (fill) begin
      valid[lookup_index] <= 1'b1;
    end
  end

  // tag captured with each fill
  always_ff @(posedge clk) begin
    if (fill) begin
      tags[lookup_index] <= lookup_tag;
    end
  end

endmodule

`default_nettype wire

//--- icache_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_consts.svh"

module icache_top (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ar_valid,
  input  logic [`ICACHE_ADDR_W-1:0] ar_addr,
  output logic                      ar_ready,
  output logic                      r_valid,
  output icache_pkg::word_t         r_data,
  input  logic                      r_ready,
  output logic                      mem_ar_valid,
  output logic [`ICACHE_ADDR_W-1:0] mem_ar_addr,
  output logic [7:0]                mem_ar_len,
  input  logic                      mem_ar_ready,
  input  logic                      mem_r_valid,
  input  icache_pkg::beat_t         mem_r_data,
  input  logic                      mem_r_last,
  output logic                      mem_r_ready,
  input  logic                      flush_req,
  output logic                      flush_ack,
  output logic [31:0]               hit_count,
  output logic [31:0]               miss_count
);

  icache_pkg::index_t        lookup_index;
  icache_pkg::tag_t          lookup_tag;
  logic                      fill;
  logic                      invalidate;
  logic                      hit;
  icache_pkg::index_t        rd_index;
  icache_pkg::woff_t         rd_off;
  icache_pkg::word_t         rd_word;
  logic                      start;
  logic                      bypass;
  logic [`ICACHE_ADDR_W-1:0] word_addr;
  logic                      done;
  icache_pkg::word_t         bypass_word;
  logic                      wr_en;
  icache_pkg::index_t        wr_index;
  icache_pkg::woff_t         wr_off;
  icache_pkg::word_t         wr_word;

  icache_ctrl u_ctrl (
    .clk(clk), .rstn(rstn),
    .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
    .r_valid(r_valid), .r_data(r_data), .r_ready(r_ready),
    .flush_req(flush_req), .flush_ack(flush_ack),
    .hit_count(hit_count), .miss_count(miss_count),
    .lookup_index(lookup_index), .lookup_tag(lookup_tag),
    .fill(fill), .invalidate(invalidate), .hit(hit),
    .rd_index(rd_index), .rd_off(rd_off), .rd_word(rd_word),
    .start(start), .bypass(bypass), .word_addr(word_addr),
    .done(done), .bypass_word(bypass_word)
  );

  icache_tag_store u_tags (
    .clk(clk), .rstn(rstn),
    .lookup_index(lookup_index), .lookup_tag(lookup_tag),
    .fill(fill), .invalidate(invalidate), .hit(hit)
  );

  icache_data_store u_data (
    .clk(clk),
    .wr_en(wr_en), .wr_index(wr_index), .wr_off(wr_off), .wr_word(wr_word),
    .rd_index(rd_index), .rd_off(rd_off), .rd_word(rd_word)
  );

  icache_refill u_refill (
    .clk(clk), .rstn(rstn),
    .start(start), .bypass(bypass), .word_addr(word_addr),
    .done(done), .bypass_word(bypass_word),
    .wr_en(wr_en), .wr_index(wr_index), .wr_off(wr_off), .wr_word(wr_word),
    .mem_ar_valid(mem_ar_valid), .mem_ar_addr(mem_ar_addr),
    .mem_ar_len(mem_ar_len), .mem_ar_ready(mem_ar_ready),
    .mem_r_valid(mem_r_valid), .mem_r_data(mem_r_data),
    .mem_r_last(mem_r_last), .mem_r_ready(mem_r_ready)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_icache -o tb_icache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_icache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

//--- tb.f
+incdir+.
icache_pkg.sv
icache_tag_store.sv
icache_data_store.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

//--- tb_icache.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_consts.svh"

module tb_icache;

  localparam int KIND_HIT = 0;
  localparam int KIND_MISS = 1;
  localparam int KIND_BYPASS = 2;
  localparam int NUM_TESTS = 6;
  localparam int FETCHES_PER_TEST = 8;
  localparam int FETCH_CYCLES = 64; // 4 beats with 3 stalls, hold and lookup, with margin
  localparam int WATCHDOG_NS = (8 + NUM_TESTS * FETCHES_PER_TEST * FETCH_CYCLES) * 8;

  logic                      clk;
  logic                      rstn;
  logic                      ar_valid;
  logic [`ICACHE_ADDR_W-1:0] ar_addr;
  logic                      ar_ready;
  logic                      r_valid;
  icache_pkg::word_t         r_data;
  logic                      r_ready;
  logic                      mem_ar_valid;
  logic [`ICACHE_ADDR_W-1:0] mem_ar_addr;
  logic [7:0]                mem_ar_len;
  logic                      mem_ar_ready;
  logic                      mem_r_valid;
  icache_pkg::beat_t         mem_r_data;
  logic                      mem_r_last;
  logic                      mem_r_ready;
  logic                      flush_req;
  logic                      flush_ack;
  logic [31:0]               hit_count;
  logic [31:0]               miss_count;
  int                        req_count;
  logic [7:0]                last_len;
  int                        errors;
  integer                    seed;

  icache_top DUT (
    .clk(clk), .rstn(rstn),
    .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
    .r_valid(r_valid), .r_data(r_data), .r_ready(r_ready),
    .mem_ar_valid(mem_ar_valid), .mem_ar_addr(mem_ar_addr),
    .mem_ar_len(mem_ar_len), .mem_ar_ready(mem_ar_ready),
    .mem_r_valid(mem_r_valid), .mem_r_data(mem_r_data),
    .mem_r_last(mem_r_last), .mem_r_ready(mem_r_ready),
    .flush_req(flush_req), .flush_ack(flush_ack),
    .hit_count(hit_count), .miss_count(miss_count)
  );

  tb_mem_model mem (
    .clk(clk), .rstn(rstn),
    .ar_valid(mem_ar_valid), .ar_addr(mem_ar_addr), .ar_len(mem_ar_len),
    .ar_ready(mem_ar_ready),
    .r_valid(mem_r_valid), .r_data(mem_r_data), .r_last(mem_r_last),
    .r_ready(mem_r_ready),
    .req_count(req_count), .last_len(last_len)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'hffff_0000;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // called on a falling edge, returns on the falling edge after the r handshake
  task automatic fetch(input logic [31:0] addr, input int hold, output logic [31:0] data,
                       output int latency);
    logic [31:0] held;
    ar_valid = 1'b1;
    ar_addr  = addr;
    while (!ar_ready) @(negedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
    latency  = 0;
    while (!r_valid) begin
      check_val("ar_ready", ar_ready, 0); // busy until the response is taken
      latency++;
      @(negedge clk);
    end
    held = r_data;
    repeat (hold) begin
      @(negedge clk);
      check_val("r_valid", r_valid, 1);
      check_val("r_data", r_data, held); // stable under back-pressure
      check_val("ar_ready", ar_ready, 0);
    end
    data    = r_data;
    r_ready = 1'b1;
    @(negedge clk);
    r_ready = 1'b0;
    check_val("ar_ready", ar_ready, 1);
  endtask

  task automatic fetch_check(input logic [31:0] addr, input int kind, input int hold);
    logic [31:0] data;
    logic [31:0] hits0;
    logic [31:0] misses0;
    int          reqs0;
    int          latency;
    hits0   = hit_count;
    misses0 = miss_count;
    reqs0   = req_count;
    fetch(addr, hold, data, latency);
    check_val("r_data", data, expected_word(addr));
    check_val("hit_count", hit_count, hits0 + 32'(kind == KIND_HIT));
    check_val("miss_count", miss_count, misses0 + 32'(kind == KIND_MISS));
    check_val("req_count", req_count, reqs0 + int'(kind != KIND_HIT));
    if (kind == KIND_HIT) begin
      check_val("r_valid latency", latency, 2); // two edges after the ar handshake
    end
    if (kind != KIND_HIT) begin
      check_val("mem_ar_len", last_len, (kind == KIND_BYPASS) ? 0 : `ICACHE_WORDS - 1);
    end
  endtask

  task automatic test_cold_miss_then_hit();
    fetch_check(32'h4000_0014, KIND_MISS, 0);
    fetch_check(32'h4000_0014, KIND_HIT, 0);
  endtask

  task automatic test_wrapping_refill();
    fetch_check(32'h5000_0028, KIND_MISS, 0); // third word first
    fetch_check(32'h5000_0020, KIND_HIT, 0);
    fetch_check(32'h5000_0024, KIND_HIT, 0);
    fetch_check(32'h5000_002c, KIND_HIT, 0);
  endtask

  task automatic test_conflict_eviction();
    for (int i = 0; i < 4; i++) begin
      fetch_check(32'h6000_0030, KIND_MISS, 0); // both in set 3
      fetch_check(32'h7000_0034, KIND_MISS, 0);
    end
  endtask

  task automatic test_uncached_bypass();
    for (int i = 0; i < 2; i++) begin
      fetch_check(32'h1000_0040, KIND_BYPASS, 0);
      fetch_check(32'h2fff_fffc, KIND_BYPASS, 0);
      fetch_check(32'h0000_0008, KIND_BYPASS, 0);
    end
  endtask

  task automatic test_flush_handshake();
    int wait_cycles;
    fetch_check(32'h4000_0014, KIND_HIT, 0);
    check_val("flush_ack", flush_ack, 0);
    flush_req   = 1'b1;
    wait_cycles = 0;
    while (!flush_ack && wait_cycles < 16) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!flush_ack) begin
      $display("flush_ack did not rise within 16 cycles of flush_req");
      errors++;
    end
    repeat (3) @(negedge clk);
    check_val("flush_ack", flush_ack, 1); // held while req stays high
    flush_req   = 1'b0;
    wait_cycles = 0;
    while (flush_ack && wait_cycles < 16) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (flush_ack) begin
      $display("flush_ack stayed high after flush_req was dropped");
      errors++;
    end
    fetch_check(32'h4000_0014, KIND_MISS, 0);
    fetch_check(32'h5000_0020, KIND_MISS, 0);
  endtask

  task automatic test_back_pressure();
    logic [31:0] addrs [6];
    int          kinds [6];
    int          hold;
    addrs = '{32'h4000_0018, 32'h8000_0004, 32'h8000_000c,
              32'h0000_0100, 32'h6000_003c, 32'h1234_5678};
    kinds = '{KIND_HIT, KIND_MISS, KIND_HIT, KIND_BYPASS, KIND_MISS, KIND_BYPASS};
    for (int i = 0; i < 6; i++) begin
      hold = 1 + $unsigned($random(seed)) % 6;
      fetch_check(addrs[i], kinds[i], hold);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    errors    = 0;
    seed      = 32'hcd2d_f7ad;
    rstn      = 1'b0;
    ar_valid  = 1'b0;
    ar_addr   = '0;
    r_ready   = 1'b0;
    flush_req = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_val("ar_ready", ar_ready, 1);
    check_val("r_valid", r_valid, 0);
    check_val("mem_ar_valid", mem_ar_valid, 0);
    check_val("mem_r_ready", mem_r_ready, 0);
    check_val("flush_ack", flush_ack, 0);
    check_val("hit_count", hit_count, 0);
    check_val("miss_count", miss_count, 0);
    test_cold_miss_then_hit();
    test_wrapping_refill();
    test_conflict_eviction();
    test_uncached_bypass();
    test_flush_handshake();
    test_back_pressure();
    $display("tests done, %0d errors, hits %0d, misses %0d", errors, hit_count, miss_count);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`default_nettype none
`timescale 1ns/100ps

module tb_mem_model (
  input  logic        clk,
  input  logic        rstn,
  input  logic        ar_valid,
  input  logic [31:0] ar_addr,
  input  logic [7:0]  ar_len,
  output logic        ar_ready,
  output logic        r_valid,
  output logic [63:0] r_data,
  output logic        r_last,
  input  logic        r_ready,
  output int          req_count,
  output logic [7:0]  last_len
);

  integer seed;

  // word address with its upper half inverted, placed in the half picked by bit 2
  function automatic logic [63:0] beat_for(input logic [31:0] addr);
    logic [31:0] w;
    w = {addr[31:2], 2'b00} ^ 32'hffff_0000;
    return addr[2] ? {w, 32'h0} : {32'h0, w};
  endfunction

  initial begin
    logic [31:0] base;
    int          beats;
    int          stall;
    seed      = 32'hcd2d_f7ad;
    ar_ready  = 1'b0;
    r_valid   = 1'b0;
    r_data    = '0;
    r_last    = 1'b0;
    req_count = 0;
    last_len  = '0;
    forever begin
      @(negedge clk);
      ar_ready = 1'b1;
      @(posedge clk);
      while (!(rstn && ar_valid)) @(posedge clk);
      base     = ar_addr;
      beats    = int'(ar_len) + 1;
      last_len = ar_len;
      req_count++;
      @(negedge clk);
      ar_ready = 1'b0;
      for (int i = 0; i < beats; i++) begin
        stall = $unsigned($random(seed)) % 4;
        repeat (stall) @(negedge clk);
        r_valid = 1'b1;
        r_data  = beat_for({base[31:4], base[3:2] + 2'(i), 2'b00}); // wraps in the line
        r_last  = (i == beats - 1);
        @(posedge clk);
        while (!r_ready) @(posedge clk);
        @(negedge clk);
        r_valid = 1'b0;
        r_last  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
